/* csr_consts.svh */
// RV32 machine-mode CSR map; timer CSR addresses are core specific, not the privileged spec
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////
`define CSR_ADDR_W        12
`define CSR_DATA_W        32
`define CAUSE_W           6    // IRQ flag + 5-bit code
`define TVEC_W            24   // Upper bits of mtvec

////////////////////////////////////////////////////////////
// CSR addresses
////////////////////////////////////////////////////////////
`define CSR_MSTATUS       12'h300
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MCYCLE        12'hB00
`define CSR_MCYCLEH       12'hB80
`define CSR_MTIME         12'hB01   // Non-standard location
`define CSR_MTIMEH        12'hB41
`define CSR_MTIMECMP      12'h321   // Non-standard location
`define CSR_MTIMECMPH     12'h322
`define CSR_PMPADDR_BASE  12'h3B0   // First protection address

// Bit positions
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7
`define MSTATUS_MPP_LSB   11  // Two bits wide
`define MSTATUS_MPRV_BIT  17
`define MIE_MTIE_BIT      7
`define MIP_MTIP_BIT      7

`define MTVEC_MODE        2'b01  // Vectored, read-only
`define N_PMP_DEFAULT     4

`endif

/* csr_pkg.sv */
// CSR access types; op encoding matches the decode stage of the core
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

  // Access operation from decode
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Request as presented by the core, single cycle
  typedef struct packed {
    logic                   access;  // Qualifies the write, reads are always live
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_DATA_W-1:0] wdata;
    csr_op_e                op;
  } csr_req_t;

  // Internal write bus, op already resolved
  typedef struct packed {
    logic                   we;
    logic [`CSR_ADDR_W-1:0] addr;  // Also drives block read decode
    logic [`CSR_DATA_W-1:0] data;  // Final value to store
  } csr_wr_t;

endpackage

`default_nettype wire

/* priv_pkg.sv */
// Privilege and trap types; only user and machine levels exist
`default_nettype none

`include "csr_consts.svh"

package priv_pkg;

  // Encoding as in the mstatus MPP field
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Implemented mstatus fields, rest read zero
  typedef struct packed {
    logic      mie;   // Global M interrupt enable
    logic      mpie;  // mie before last trap
    priv_lvl_e mpp;   // Level before last trap
    logic      mprv;
  } mstatus_t;

  ////////////////////////////////////////////////////////////
  // Trap request from the controller
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                   save_cause;    // Trap entry
    logic                   save_if;       // PC select, one hot
    logic                   save_id;
    logic                   save_ex;
    logic                   restore_mret;  // Return from trap
    logic [`CAUSE_W-1:0]    cause;         // MSB flags an interrupt
    logic [`CSR_DATA_W-1:0] pc_if;
    logic [`CSR_DATA_W-1:0] pc_id;
    logic [`CSR_DATA_W-1:0] pc_ex;
  } trap_req_t;

endpackage

`default_nettype wire

/* csr_access.sv */
// Combinational only; the blocks must return zero for addresses they do not own
`default_nettype none

`include "csr_consts.svh"

module csr_access (
  input  csr_pkg::csr_req_t       csr_req_i,
  input  logic [`CSR_DATA_W-1:0]  trap_rdata_i,
  input  logic [`CSR_DATA_W-1:0]  timer_rdata_i,
  input  logic [`CSR_DATA_W-1:0]  pmp_rdata_i,
  output csr_pkg::csr_wr_t        csr_wr_o,
  output logic [`CSR_DATA_W-1:0]  csr_rdata_o
);

  import csr_pkg::*;

  logic [`CSR_DATA_W-1:0] rdata;  // Merged read word

  // Unowned addresses contribute zero, so a plain OR is the mux
  assign rdata       = trap_rdata_i | timer_rdata_i | pmp_rdata_i;
  assign csr_rdata_o = rdata;

  ////////////////////////////////////////////////////////////
  // Operation logic
  ////////////////////////////////////////////////////////////
  always_comb begin
    csr_wr_o.addr = csr_req_i.addr;  // Blocks decode this
    csr_wr_o.we   = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE);

    case (csr_req_i.op)
      CSR_OP_WRITE: csr_wr_o.data = csr_req_i.wdata;
      CSR_OP_SET:   csr_wr_o.data = csr_req_i.wdata | rdata;     // Read-modify-write
      CSR_OP_CLEAR: csr_wr_o.data = (~csr_req_i.wdata) & rdata;
      default:      csr_wr_o.data = csr_req_i.wdata;             // No write, value unused
    endcase
  end

endmodule

`default_nettype wire

/* csr_trap_ctrl.sv */
// mstatus/mtvec/mepc/mcause and privilege; trap entry overrides any same-cycle CSR write
`default_nettype none

`include "csr_consts.svh"

module csr_trap_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  csr_pkg::csr_wr_t        csr_wr_i,
  input  priv_pkg::trap_req_t     trap_i,
  output logic [`CSR_DATA_W-1:0]  rdata_o,
  output priv_pkg::priv_lvl_e     priv_lvl_o,
  output logic                    mstatus_mie_o,
  output logic                    m_irq_enable_o,
  output logic [`TVEC_W-1:0]      mtvec_o,
  output logic [`CSR_DATA_W-1:0]  mepc_o
);

  import priv_pkg::*;

  localparam int TVEC_PAD = `CSR_DATA_W - `TVEC_W - 2;  // Zeros between base and mode

  mstatus_t               mstatus_q, mstatus_d;
  logic [`TVEC_W-1:0]     mtvec_q, mtvec_d;
  logic [`CSR_DATA_W-1:0] mepc_q, mepc_d;
  logic [`CAUSE_W-1:0]    mcause_q, mcause_d;
  priv_lvl_e              priv_lvl_q, priv_lvl_d;
  logic [`CSR_DATA_W-1:0] trap_pc;  // PC saved on entry
  logic [1:0]             wr_mpp;   // Raw MPP write field

  ////////////////////////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    rdata_o = '0;
    case (csr_wr_i.addr)
      `CSR_MSTATUS: begin
        rdata_o[`MSTATUS_MIE_BIT]        = mstatus_q.mie;
        rdata_o[`MSTATUS_MPIE_BIT]       = mstatus_q.mpie;
        rdata_o[`MSTATUS_MPP_LSB +: 2]   = mstatus_q.mpp;
        rdata_o[`MSTATUS_MPRV_BIT]       = mstatus_q.mprv;
      end
      `CSR_MTVEC:  rdata_o = {mtvec_q, {TVEC_PAD{1'b0}}, `MTVEC_MODE};
      `CSR_MEPC:   rdata_o = mepc_q;
      `CSR_MCAUSE: rdata_o = {mcause_q[`CAUSE_W-1], {(`CSR_DATA_W-`CAUSE_W){1'b0}},
                              mcause_q[`CAUSE_W-2:0]};
      default: ;
    endcase
  end

  // Exception PC, id stage unless flagged otherwise
  always_comb begin
    if (trap_i.save_if)      trap_pc = trap_i.pc_if;
    else if (trap_i.save_id) trap_pc = trap_i.pc_id;
    else if (trap_i.save_ex) trap_pc = trap_i.pc_ex;
    else                     trap_pc = trap_i.pc_id;
  end

  assign wr_mpp = csr_wr_i.data[`MSTATUS_MPP_LSB +: 2];

  ////////////////////////////////////////////////////////////
  // Next state: CSR write, then trap/mret on top
  ////////////////////////////////////////////////////////////
  always_comb begin
    mstatus_d  = mstatus_q;
    mtvec_d    = mtvec_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    priv_lvl_d = priv_lvl_q;

    if (csr_wr_i.we) begin
      case (csr_wr_i.addr)
        `CSR_MSTATUS: begin
          mstatus_d.mie  = csr_wr_i.data[`MSTATUS_MIE_BIT];
          mstatus_d.mpie = csr_wr_i.data[`MSTATUS_MPIE_BIT];
          mstatus_d.mpp  = (wr_mpp == PRIV_LVL_M) ? PRIV_LVL_M : PRIV_LVL_U;  // Only U/M legal
          mstatus_d.mprv = csr_wr_i.data[`MSTATUS_MPRV_BIT];
        end
        `CSR_MTVEC:  mtvec_d  = csr_wr_i.data[`CSR_DATA_W-1 -: `TVEC_W];
        `CSR_MEPC:   mepc_d   = csr_wr_i.data;
        `CSR_MCAUSE: mcause_d = {csr_wr_i.data[`CSR_DATA_W-1], csr_wr_i.data[`CAUSE_W-2:0]};
        default: ;
      endcase
    end

    if (trap_i.save_cause) begin     // Entry wins over mret
      mepc_d         = trap_pc;
      mcause_d       = trap_i.cause;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;         // Handler runs masked
      mstatus_d.mpp  = PRIV_LVL_U;
      priv_lvl_d     = PRIV_LVL_M;
    end else if (trap_i.restore_mret) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
      mstatus_d.mpp  = PRIV_LVL_U;
      priv_lvl_d     = PRIV_LVL_U;   // Always back to user
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= '{mie: 1'b0, mpie: 1'b1, mpp: PRIV_LVL_U, mprv: 1'b0};
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      priv_lvl_q <= PRIV_LVL_M;      // Boot in machine mode
    end else begin
      mstatus_q  <= mstatus_d;
      mtvec_q    <= mtvec_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      priv_lvl_q <= priv_lvl_d;
    end
  end

  assign priv_lvl_o     = priv_lvl_q;
  assign mstatus_mie_o  = mstatus_q.mie;
  assign m_irq_enable_o = mstatus_q.mie && (priv_lvl_q == PRIV_LVL_M);
  assign mtvec_o        = mtvec_q;
  assign mepc_o         = mepc_q;

endmodule

`default_nettype wire

/* csr_timer.sv */
// Counters and machine timer; MTIP is sticky and only a write to mtimecmp clears it
`default_nettype none

`include "csr_consts.svh"

module csr_timer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  csr_pkg::csr_wr_t        csr_wr_i,
  input  logic                    mstatus_mie_i,
  output logic [`CSR_DATA_W-1:0]  rdata_o,
  output logic [`CSR_DATA_W-1:0]  mip_o
);

  localparam int CNT_W = 2 * `CSR_DATA_W;  // Counters are two CSR halves
  localparam int HI    = `CSR_DATA_W;      // LSB of upper half

  logic [CNT_W-1:0]       mcycle_q, mcycle_d;
  logic [CNT_W-1:0]       mtime_q, mtime_d;
  logic [CNT_W-1:0]       mtimecmp_q, mtimecmp_d;
  logic [`CSR_DATA_W-1:0] mie_q, mie_d;
  logic                   mtip_q, mtip_d;
  logic                   cmp_wr;         // Any mtimecmp half written
  logic                   timer_expired;

  // Read decode
  always_comb begin
    case (csr_wr_i.addr)
      `CSR_MCYCLE:    rdata_o = mcycle_q[HI-1:0];
      `CSR_MCYCLEH:   rdata_o = mcycle_q[CNT_W-1:HI];
      `CSR_MTIME:     rdata_o = mtime_q[HI-1:0];
      `CSR_MTIMEH:    rdata_o = mtime_q[CNT_W-1:HI];
      `CSR_MTIMECMP:  rdata_o = mtimecmp_q[HI-1:0];
      `CSR_MTIMECMPH: rdata_o = mtimecmp_q[CNT_W-1:HI];
      `CSR_MIE:       rdata_o = mie_q;
      default:        rdata_o = '0;
    endcase
  end

  assign cmp_wr = csr_wr_i.we && ((csr_wr_i.addr == `CSR_MTIMECMP) ||
                                  (csr_wr_i.addr == `CSR_MTIMECMPH));
  assign timer_expired = (mtime_q >= mtimecmp_q);

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    mcycle_d   = mcycle_q + 1'b1;  // Free running
    mtime_d    = mtime_q + 1'b1;
    mtimecmp_d = mtimecmp_q;
    mie_d      = mie_q;
    if (csr_wr_i.we) begin         // A written half replaces the increment
      case (csr_wr_i.addr)
        `CSR_MCYCLE:    mcycle_d   = {mcycle_q[CNT_W-1:HI], csr_wr_i.data};
        `CSR_MCYCLEH:   mcycle_d   = {csr_wr_i.data, mcycle_q[HI-1:0]};
        `CSR_MTIME:     mtime_d    = {mtime_q[CNT_W-1:HI], csr_wr_i.data};
        `CSR_MTIMEH:    mtime_d    = {csr_wr_i.data, mtime_q[HI-1:0]};
        `CSR_MTIMECMP:  mtimecmp_d = {mtimecmp_q[CNT_W-1:HI], csr_wr_i.data};
        `CSR_MTIMECMPH: mtimecmp_d = {csr_wr_i.data, mtimecmp_q[HI-1:0]};
        `CSR_MIE:       mie_d      = csr_wr_i.data;
        default: ;
      endcase
    end

    // Clear has priority over set
    if (cmp_wr)
      mtip_d = 1'b0;
    else if (timer_expired && mstatus_mie_i && mie_q[`MIE_MTIE_BIT])
      mtip_d = 1'b1;
    else
      mtip_d = mtip_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q   <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // Max compare, timer idle after reset
      mie_q      <= '0;
      mtip_q     <= 1'b0;
    end else begin
      mcycle_q   <= mcycle_d;
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      mie_q      <= mie_d;
      mtip_q     <= mtip_d;
    end
  end

  // Only MTIP implemented
  always_comb begin
    mip_o                = '0;
    mip_o[`MIP_MTIP_BIT] = mtip_q;
  end

endmodule

`default_nettype wire

/* csr_pmp_bank.sv */
// Protection address bank at consecutive CSRs from the base; no pmpcfg, no locking
`default_nettype none

`include "csr_consts.svh"

module csr_pmp_bank #(
  parameter int N_PMP = `N_PMP_DEFAULT
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  csr_pkg::csr_wr_t                   csr_wr_i,
  output logic [`CSR_DATA_W-1:0]             rdata_o,
  output logic [N_PMP-1:0][`CSR_DATA_W-1:0]  pmp_addr_o
);

  logic [N_PMP-1:0][`CSR_DATA_W-1:0] pmp_addr_q;
  logic [N_PMP-1:0]                  hit;  // Address decode per entry

  for (genvar i = 0; i < N_PMP; i++) begin : g_entry
    localparam logic [`CSR_ADDR_W-1:0] ENTRY_ADDR = `CSR_ADDR_W'(`CSR_PMPADDR_BASE + i);

    assign hit[i] = (csr_wr_i.addr == ENTRY_ADDR);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        pmp_addr_q[i] <= '0;
      end else if (csr_wr_i.we && hit[i]) begin  // Own enable per entry
        pmp_addr_q[i] <= csr_wr_i.data;
      end
    end
  end

  // Readback, zero past the last entry
  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < N_PMP; i++) begin
      if (hit[i]) rdata_o = pmp_addr_q[i];
    end
  end

  assign pmp_addr_o = pmp_addr_q;  // Whole bank to the PMP checker

endmodule

`default_nettype wire

/* csr_top.sv */
// CSR file top; accesses complete in one cycle, no stall, reads combinational
`default_nettype none

`include "csr_consts.svh"

module csr_top #(
  parameter int N_PMP = `N_PMP_DEFAULT
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  csr_pkg::csr_req_t                  csr_req_i,     // From decode
  input  priv_pkg::trap_req_t                trap_i,        // From controller
  output logic [`CSR_DATA_W-1:0]             csr_rdata_o,
  output priv_pkg::priv_lvl_e                priv_lvl_o,
  output logic                               m_irq_enable_o,
  output logic [`TVEC_W-1:0]                 mtvec_o,
  output logic [`CSR_DATA_W-1:0]             mepc_o,
  output logic [`CSR_DATA_W-1:0]             mip_o,
  output logic [N_PMP-1:0][`CSR_DATA_W-1:0]  pmp_addr_o
);

  import csr_pkg::*;

  csr_wr_t                csr_wr;       // Shared write bus
  logic [`CSR_DATA_W-1:0] trap_rdata;
  logic [`CSR_DATA_W-1:0] timer_rdata;
  logic [`CSR_DATA_W-1:0] pmp_rdata;
  logic                   mstatus_mie;  // Gates timer pending

  ////////////////////////////////////////////////////////////
  // Access unit
  ////////////////////////////////////////////////////////////
  csr_access i_access (
    .csr_req_i     (csr_req_i),
    .trap_rdata_i  (trap_rdata),
    .timer_rdata_i (timer_rdata),
    .pmp_rdata_i   (pmp_rdata),
    .csr_wr_o      (csr_wr),
    .csr_rdata_o   (csr_rdata_o)
  );

  // Register blocks
  csr_trap_ctrl i_trap_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_wr_i       (csr_wr),
    .trap_i         (trap_i),
    .rdata_o        (trap_rdata),
    .priv_lvl_o     (priv_lvl_o),
    .mstatus_mie_o  (mstatus_mie),
    .m_irq_enable_o (m_irq_enable_o),
    .mtvec_o        (mtvec_o),
    .mepc_o         (mepc_o)
  );

  csr_timer i_timer (
    .clk           (clk),
    .rst_n         (rst_n),
    .csr_wr_i      (csr_wr),
    .mstatus_mie_i (mstatus_mie),
    .rdata_o       (timer_rdata),
    .mip_o         (mip_o)
  );

  csr_pmp_bank #(
    .N_PMP (N_PMP)
  ) i_pmp_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_wr_i   (csr_wr),
    .rdata_o    (pmp_rdata),
    .pmp_addr_o (pmp_addr_o)
  );

endmodule

`default_nettype wire

/* tb_csr_top.sv */
// Expects N_PMP = 4 and the timer CSR map of csr_consts.svh; seeded random data, not exhaustive
`default_nettype none

`include "csr_consts.svh"

module tb_csr_top;

  timeunit 1ns;
  timeprecision 100ps;

  import csr_pkg::*;
  import priv_pkg::*;

  localparam int          N_PMP      = 4;
  localparam int          TIMER_WAIT = 64;  // MTIP poll bound in cycles
  localparam int          CMP_AHEAD  = 16;  // mtimecmp distance past mtime
  localparam logic [31:0] SEED       = 32'h53f35dbc;
  localparam logic [31:0] MS_MIE     = 32'h1 << `MSTATUS_MIE_BIT;
  localparam logic [31:0] MS_MPIE    = 32'h1 << `MSTATUS_MPIE_BIT;
  localparam logic [31:0] MS_MPP     = 32'h3 << `MSTATUS_MPP_LSB;
  localparam logic [31:0] MTIE       = 32'h1 << `MIE_MTIE_BIT;
  // Care flags per row
  localparam logic [5:0]  C_NONE = 6'b000000;
  localparam logic [5:0]  C_RD   = 6'b000001;
  localparam logic [5:0]  C_PRIV = 6'b000010;
  localparam logic [5:0]  C_MEPC = 6'b000100;
  localparam logic [5:0]  C_MIP  = 6'b001000;
  localparam logic [5:0]  C_PMP  = 6'b010000;
  localparam logic [5:0]  C_CTRL = 6'b100000;  // mtvec_o and m_irq_enable_o

  typedef logic [N_PMP-1:0][31:0] pmp_vec_t;

  // One table row per cycle
  typedef struct packed {
    logic [2:0]         test_id;
    csr_req_t           req;
    trap_req_t          trap;
    logic [5:0]         care;
    logic [31:0]        exp_rd;
    priv_lvl_e          exp_priv;
    logic [31:0]        exp_mepc;
    logic [31:0]        exp_mip;
    pmp_vec_t           exp_pmp;
    logic [`TVEC_W-1:0] exp_tvec;
    logic               exp_irq;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  csr_req_t               csr_req;
  trap_req_t              trap;
  logic [31:0]            csr_rdata;
  priv_lvl_e              priv_lvl;
  logic                   m_irq_enable;
  logic [`TVEC_W-1:0]     mtvec;
  logic [31:0]            mepc;
  logic [31:0]            mip;
  pmp_vec_t               pmp_addr;

  row_t        rows[$];
  trap_req_t   next_trap = '0;                     // Trap for the next pushed row
  priv_lvl_e   e_priv;                             // Expected state while building
  logic [31:0] e_mepc, e_mip;
  pmp_vec_t    e_pmp;
  logic [`TVEC_W-1:0] e_tvec;
  logic        e_irq;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;
  int          err_count = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name [5] = '{"reset", "readback", "set_clear", "trap", "timer"};

  csr_top #(.N_PMP(N_PMP)) i_dut (
    .clk(clk), .rst_n(rst_n), .csr_req_i(csr_req), .trap_i(trap),
    .csr_rdata_o(csr_rdata), .priv_lvl_o(priv_lvl), .m_irq_enable_o(m_irq_enable),
    .mtvec_o(mtvec), .mepc_o(mepc), .mip_o(mip), .pmp_addr_o(pmp_addr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks and drive
  ////////////////////////////////////////////////////////////
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("%s", what);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %-10s passed", name);
    end else begin
      $display("test %-10s failed, %0d bad checks", name, test_errs);
      tests_failed++;
    end
    err_count += test_errs;
    test_errs  = 0;
  endtask

  function automatic csr_req_t req_of(input logic acc, input csr_op_e op,
                                      input logic [11:0] addr, input logic [31:0] data);
    return '{access: acc, addr: addr, wdata: data, op: op};
  endfunction

  task automatic step(input csr_req_t req, input trap_req_t tr);
    @(posedge clk);
    csr_req <= req;
    trap    <= tr;
    @(negedge clk);  // Outputs settled here
  endtask

  task automatic check_row(input row_t r);
    if (r.care[0]) check_word("csr_rdata_o", csr_rdata, r.exp_rd);
    if (r.care[1]) check_word("priv_lvl_o", 32'(priv_lvl), 32'(r.exp_priv));
    if (r.care[2]) check_word("mepc_o", mepc, r.exp_mepc);
    if (r.care[3]) check_word("mip_o", mip, r.exp_mip);
    if (r.care[4]) begin
      for (int i = 0; i < N_PMP; i++)
        check_word($sformatf("pmp_addr_o[%0d]", i), pmp_addr[i], r.exp_pmp[i]);
    end
    if (r.care[5]) begin
      check_word("mtvec_o", 32'(mtvec), 32'(r.exp_tvec));
      check_word("m_irq_enable_o", 32'(m_irq_enable), 32'(r.exp_irq));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Table building
  ////////////////////////////////////////////////////////////
  task automatic push_row(input logic [2:0] id, input logic acc, input csr_op_e op,
                          input logic [11:0] addr, input logic [31:0] data,
                          input logic [5:0] care, input logic [31:0] exp_rd);
    row_t r;
    r          = '0;
    r.test_id  = id;
    r.req      = req_of(acc, op, addr, data);
    r.trap     = next_trap;
    r.care     = care;
    r.exp_rd   = exp_rd;
    r.exp_priv = e_priv;  // Snapshot of expected state
    r.exp_mepc = e_mepc;
    r.exp_mip  = e_mip;
    r.exp_pmp  = e_pmp;
    r.exp_tvec = e_tvec;
    r.exp_irq  = e_irq;
    rows.push_back(r);
    next_trap  = '0;
  endtask

  task automatic wr(input logic [2:0] id, input csr_op_e op, input logic [11:0] addr,
                    input logic [31:0] data);
    push_row(id, 1'b1, op, addr, data, C_NONE, '0);
  endtask

  task automatic rd(input logic [2:0] id, input logic [11:0] addr, input logic [31:0] exp,
                    input logic [5:0] care);
    push_row(id, 1'b0, CSR_OP_NONE, addr, '0, C_RD | care, exp);
  endtask

  function automatic trap_req_t trap_entry(input int sel, input logic [5:0] cause,
                                           input logic [31:0] pc_if, pc_id, pc_ex);
    trap_req_t t;
    t            = '0;
    t.save_cause = 1'b1;
    t.save_if    = (sel == 0);
    t.save_id    = (sel == 1);
    t.save_ex    = (sel == 2);
    t.cause      = cause;
    t.pc_if      = pc_if;
    t.pc_id      = pc_id;
    t.pc_ex      = pc_ex;
    return t;
  endfunction

  // IRQ flag to bit 31 and code in the low bits
  function automatic logic [31:0] mcause_word(input logic [5:0] c);
    return {c[`CAUSE_W-1], {(32-`CAUSE_W){1'b0}}, c[`CAUSE_W-2:0]};
  endfunction

  task automatic build_table();
    logic [31:0] v_tvec, v_mie, v_time, pc_if, pc_id, pc_ex;
    logic [5:0]  cause;
    e_priv = PRIV_LVL_M;
    e_mepc = '0;
    e_mip  = '0;
    e_pmp  = '0;
    e_tvec = '0;
    e_irq  = 1'b0;
    // Reset values
    rd(0, `CSR_MSTATUS, MS_MPIE, C_PRIV | C_MIP | C_PMP | C_MEPC | C_CTRL);
    rd(0, `CSR_MTIMECMP, '1, C_NONE);
    rd(0, `CSR_MTIMECMPH, '1, C_NONE);
    rd(0, `CSR_MTVEC, {30'b0, `MTVEC_MODE}, C_NONE);
    // Readback
    v_tvec = $urandom();
    wr(1, CSR_OP_WRITE, `CSR_MTVEC, v_tvec);
    e_tvec = v_tvec[31 -: `TVEC_W];                     // Base kept, mode bits fixed
    rd(1, `CSR_MTVEC, {e_tvec, 8'(`MTVEC_MODE)}, C_CTRL);
    e_mepc = $urandom();
    wr(1, CSR_OP_WRITE, `CSR_MEPC, e_mepc);
    rd(1, `CSR_MEPC, e_mepc, C_MEPC);
    for (int i = 0; i < N_PMP; i++) begin
      e_pmp[i] = $urandom();
      wr(1, CSR_OP_WRITE, 12'(`CSR_PMPADDR_BASE + i), e_pmp[i]);
    end
    for (int i = 0; i < N_PMP; i++)
      rd(1, 12'(`CSR_PMPADDR_BASE + i), e_pmp[i], C_PMP);
    rd(1, 12'(`CSR_PMPADDR_BASE + N_PMP), '0, C_NONE);     // Past the bank
    wr(1, CSR_OP_WRITE, 12'(`CSR_PMPADDR_BASE + N_PMP), $urandom());
    rd(1, 12'(`CSR_PMPADDR_BASE + N_PMP), '0, C_PMP | C_MEPC | C_CTRL);
    wr(1, CSR_OP_WRITE, 12'h7C0, $urandom());
    rd(1, 12'h7C0, '0, C_PMP | C_MEPC | C_CTRL);
    // Set and clear
    wr(2, CSR_OP_SET, `CSR_MSTATUS, MS_MIE);
    e_irq = 1'b1;                                       // mie set in machine mode
    rd(2, `CSR_MSTATUS, MS_MPIE | MS_MIE, C_CTRL);
    wr(2, CSR_OP_CLEAR, `CSR_MSTATUS, MS_MPIE);
    rd(2, `CSR_MSTATUS, MS_MIE, C_NONE);
    wr(2, CSR_OP_SET, `CSR_MSTATUS, MS_MPP);
    rd(2, `CSR_MSTATUS, MS_MPP | MS_MIE, C_NONE);
    wr(2, CSR_OP_CLEAR, `CSR_MSTATUS, MS_MPP);
    rd(2, `CSR_MSTATUS, MS_MIE, C_NONE);
    v_mie = $urandom() & ~MTIE;                           // Timer stays masked for now
    wr(2, CSR_OP_WRITE, `CSR_MIE, v_mie);
    rd(2, `CSR_MIE, v_mie, C_NONE);
    wr(2, CSR_OP_SET, `CSR_MIE, MTIE);
    rd(2, `CSR_MIE, v_mie | MTIE, C_NONE);
    wr(2, CSR_OP_CLEAR, `CSR_MIE, MTIE);
    rd(2, `CSR_MIE, v_mie, C_NONE);
    push_row(2, 1'b1, CSR_OP_NONE, `CSR_MIE, '1, C_NONE, '0);
    rd(2, `CSR_MIE, v_mie, C_NONE);
    push_row(2, 1'b0, CSR_OP_WRITE, `CSR_MIE, '1, C_NONE, '0);
    rd(2, `CSR_MIE, v_mie, C_NONE);
    push_row(2, 1'b0, CSR_OP_CLEAR, `CSR_MSTATUS, '1, C_NONE, '0);
    rd(2, `CSR_MSTATUS, MS_MIE, C_PRIV | C_CTRL);
    // Trap entry starts with mie set
    pc_if = $urandom();
    pc_id = $urandom();
    pc_ex = $urandom();
    cause = 6'($urandom());
    next_trap = trap_entry(0, cause, pc_if, pc_id, pc_ex);
    push_row(3, 1'b0, CSR_OP_NONE, `CSR_MCAUSE, '0, C_NONE, '0);
    e_mepc = pc_if;
    e_irq  = 1'b0;                                      // Handler entered masked
    rd(3, `CSR_MCAUSE, mcause_word(cause), C_PRIV | C_MEPC | C_CTRL);
    rd(3, `CSR_MSTATUS, MS_MPIE, C_NONE);
    next_trap = trap_entry(1, ~cause, pc_if, pc_id, pc_ex);
    push_row(3, 1'b1, CSR_OP_WRITE, `CSR_MEPC, $urandom(), C_NONE, '0);  // Loses to trap
    e_mepc = pc_id;
    rd(3, `CSR_MEPC, pc_id, C_MEPC);
    rd(3, `CSR_MCAUSE, mcause_word(~cause), C_NONE);
    rd(3, `CSR_MSTATUS, '0, C_NONE);
    wr(3, CSR_OP_WRITE, `CSR_MSTATUS, MS_MIE);
    next_trap = trap_entry(2, cause, pc_if, pc_id, pc_ex);
    e_irq = 1'b1;
    push_row(3, 1'b0, CSR_OP_NONE, `CSR_MEPC, '0, C_CTRL, '0);
    e_mepc = pc_ex;
    e_irq  = 1'b0;
    rd(3, `CSR_MSTATUS, MS_MPIE, C_MEPC | C_PRIV | C_CTRL);
    next_trap.restore_mret = 1'b1;
    push_row(3, 1'b0, CSR_OP_NONE, `CSR_MSTATUS, '0, C_NONE, '0);
    e_priv = PRIV_LVL_U;                                // mie back on but user level
    rd(3, `CSR_MSTATUS, MS_MIE | MS_MPIE, C_PRIV | C_MEPC | C_CTRL);
    // Timer load with the low half kept clear of a wrap
    v_time = $urandom() & 32'h0fff_ffff;
    wr(4, CSR_OP_WRITE, `CSR_MTIMEH, '0);
    wr(4, CSR_OP_WRITE, `CSR_MTIME, v_time);
    rd(4, `CSR_MTIME, v_time, C_MIP);
    rd(4, `CSR_MTIMEH, '0, C_MIP);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] t, c1;
    int          n;
    csr_req = '0;
    trap    = '0;
    rst_n   = 1'b0;
    t       = $urandom(SEED);  // Seeds this thread
    build_table();
    cycle_limit = 2 * rows.size() + TIMER_WAIT;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    foreach (rows[i]) begin
      step(rows[i].req, rows[i].trap);
      check_row(rows[i]);
      if (i == rows.size() - 1 || rows[i + 1].test_id != rows[i].test_id)
        finish_test(test_name[rows[i].test_id]);
    end

    // Timer pending needs mstatus mie, which mret left set
    step(req_of(1'b1, CSR_OP_SET, `CSR_MIE, MTIE), '0);
    step(req_of(1'b1, CSR_OP_WRITE, `CSR_MTIMECMPH, '0), '0);
    step(req_of(1'b0, CSR_OP_NONE, `CSR_MTIME, '0), '0);
    t = csr_rdata;
    step(req_of(1'b1, CSR_OP_WRITE, `CSR_MTIMECMP, t + CMP_AHEAD), '0);
    n = 0;
    while (mip[`MIP_MTIP_BIT] !== 1'b1 && n < TIMER_WAIT) begin
      step(req_of(1'b0, CSR_OP_NONE, `CSR_MTIME, '0), '0);
      n++;
    end
    check_true(mip[`MIP_MTIP_BIT] === 1'b1,
               $sformatf("timer pending bit not set within %0d cycles", TIMER_WAIT));
    step(req_of(1'b1, CSR_OP_WRITE, `CSR_MTIMECMP, '1), '0);  // Clears MTIP
    step(req_of(1'b0, CSR_OP_NONE, `CSR_MTIME, '0), '0);
    check_word("mip_o", mip, '0);
    finish_test("timer_irq");

    // mcycle keeps counting
    step(req_of(1'b0, CSR_OP_NONE, `CSR_MCYCLE, '0), '0);
    c1 = csr_rdata;
    repeat (5) step(req_of(1'b0, CSR_OP_NONE, `CSR_MCYCLE, '0), '0);
    check_true(csr_rdata > c1,
               $sformatf("mcycle did not advance: 0x%08h then 0x%08h", c1, csr_rdata));
    finish_test("mcycle");

    $display("tests %0d, failed %0d, bad checks %0d", tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
csr_pkg.sv
priv_pkg.sv
csr_access.sv
csr_trap_ctrl.sv
csr_timer.sv
csr_pmp_bank.sv
csr_top.sv
tb_csr_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR testbench with Verilator, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_csr_top > sim.log 2>&1 \
  && ./obj_dir/Vtb_csr_top >> sim.log 2>&1 \
  || { echo "build or simulation failed, see sim.log"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL, no result line in sim.log"; exit 1; }
echo "PASS"
